// File: adc_rx.f
+incdir+common
common/adc_rx_pkg.sv
design/word_slip.sv
frame_align/frame_align.sv
design/sample_assembler.sv
design/adc_rx_top.sv
tb/tb_clock_gen.sv
tb/adc_rx_properties.sv
tb/adc_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ADC receive testbench with Verilator and runs it.
# Exit status is 0 only when the log holds no failure report.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation failed"

verilator --binary --timing --assert -f adc_rx.f --top-module adc_rx_tb -o adc_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/adc_rx_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulator returned status $run_status"
    exit 1
fi

exit 0

// File: tb/adc_rx_vectors.txt
// frame_raw lane0_raw lane1_raw | bitslip bitslip_count frame_valid locked sample_valid sample
// Outputs are those seen after the clock edge that drives the line's inputs
E1 A5 3C 1 1 0 0 0 0000
E1 A5 3C 0 1 0 0 0 0000
E1 A5 3C 0 1 0 0 0 0000
E1 A5 3C 0 1 1 0 0 0000
E1 A5 3C 0 1 1 0 0 0000
E1 A5 3C 0 1 1 0 0 0000
E1 A5 3C 0 1 1 0 0 0000
E1 A5 3C 0 1 1 1 0 0000
E1 A5 3C 0 1 1 1 1 1ED2
E1 A5 3C 0 1 1 1 1 1ED2
E1 A5 3C 0 1 1 1 1 1ED2
F0 D2 1E 0 1 1 1 1 1ED2
F0 D2 1E 0 1 1 1 1 1ED2
F0 D2 1E 1 2 0 1 1 1ED2
F0 D2 1E 0 2 0 0 0 0000
F0 D2 1E 0 2 0 0 0 0000
F0 D2 1E 0 2 0 0 0 0000
F0 D2 1E 1 3 0 0 0 0000
F0 D2 1E 0 3 0 0 0 0000
F0 D2 1E 0 3 0 0 0 0000
F0 D2 1E 0 3 0 0 0 0000
F0 D2 1E 1 4 0 0 0 0000
F0 D2 1E 0 4 0 0 0 0000
F0 D2 1E 0 4 0 0 0 0000
F0 D2 1E 0 4 0 0 0 0000
F0 D2 1E 1 5 0 0 0 0000
F0 D2 1E 0 5 0 0 0 0000
F0 D2 1E 0 5 0 0 0 0000
F0 D2 1E 0 5 0 0 0 0000
F0 D2 1E 1 6 0 0 0 0000
F0 D2 1E 0 6 0 0 0 0000
F0 D2 1E 0 6 0 0 0 0000
F0 D2 1E 0 6 0 0 0 0000
F0 D2 1E 1 7 0 0 0 0000
F0 D2 1E 0 7 0 0 0 0000
F0 D2 1E 0 7 0 0 0 0000
F0 D2 1E 0 7 0 0 0 0000
F0 D2 1E 1 0 0 0 0 0000
F0 D2 1E 0 0 0 0 0 0000
F0 D2 1E 0 0 0 0 0 0000
F0 D2 1E 0 0 1 0 0 0000
F0 D2 1E 0 0 1 0 0 0000
F0 D2 1E 0 0 1 0 0 0000
F0 D2 1E 0 0 1 0 0 0000
F0 D2 1E 0 0 1 1 0 0000
F0 D2 1E 0 0 1 1 1 1ED2
F0 D2 1E 0 0 1 1 1 1ED2

// File: tb/adc_rx_tb.sv
`timescale 1ns/100ps

module adc_rx_tb;

    import adc_rx_pkg::*;

    localparam int FIELDS     = 9;     // Words per vector line
    localparam int MAX_LINES  = 256;
    localparam int EDGE_LIMIT = 100;   // ns allowed for one clock edge to arrive

    logic         data_clk_div_internal;
    logic         sync_rst;
    lane_word_t   frame_raw;
    lane_word_t   lane0_raw;
    lane_word_t   lane1_raw;
    logic         bitslip;
    slip_offset_t bitslip_count;
    logic         frame_valid;
    logic         locked;
    logic         sample_valid;
    sample_t      sample;

    logic [15:0] vec_mem [0:FIELDS*MAX_LINES-1];

    tb_clock_gen #(.PERIOD_NS(4.0)) u_clock_gen (
        .data_clk_div_internal (data_clk_div_internal)
    );

    adc_rx_top u_dut (
        .data_clk_div_internal (data_clk_div_internal),
        .sync_rst              (sync_rst),
        .frame_raw             (frame_raw),
        .lane0_raw             (lane0_raw),
        .lane1_raw             (lane1_raw),
        .bitslip               (bitslip),
        .bitslip_count         (bitslip_count),
        .frame_valid           (frame_valid),
        .locked                (locked),
        .sample_valid          (sample_valid),
        .sample                (sample)
    );

    bind adc_rx_top adc_rx_properties u_properties (
        .data_clk_div_internal (data_clk_div_internal),
        .sync_rst              (sync_rst),
        .bitslip               (bitslip),
        .bitslip_count         (bitslip_count),
        .frame_valid           (frame_valid),
        .locked                (locked),
        .sample_valid          (sample_valid)
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp, input int line);
        if (got !== exp) begin
            $display("[FAIL] %s at vector %0d: got 0x%0h expected 0x%0h", name, line, got, exp);
            stop_on_error("Output mismatch");
        end
    endtask

    // Waits for one clock edge, giving up if the clock has stopped
    task automatic wait_edge(input bit rising);
        bit seen;
        seen = 1'b0;
        fork
            begin
                if (rising) @(posedge data_clk_div_internal);
                else @(negedge data_clk_div_internal);
                seen = 1'b1;
            end
            begin
                #(EDGE_LIMIT);
            end
        join_any
        disable fork;
        if (!seen) stop_on_error("Timed out waiting for a clock edge");
    endtask

    task automatic check_line(input int line);
        int b;
        b = line * FIELDS;
        compare_value("bitslip", 16'(bitslip), vec_mem[b+3], line);
        compare_value("bitslip_count", 16'(bitslip_count), vec_mem[b+4], line);
        compare_value("frame_valid", 16'(frame_valid), vec_mem[b+5], line);
        compare_value("locked", 16'(locked), vec_mem[b+6], line);
        compare_value("sample_valid", 16'(sample_valid), vec_mem[b+7], line);
        if (vec_mem[b+7] == 16'h1) begin   // Sample only means something when valid
            compare_value("sample", 16'(sample), vec_mem[b+8], line);
        end
    endtask

    initial begin
        int n_lines;

        // Bit 15 marks a word that the vector file did not fill
        for (int k = 0; k < FIELDS*MAX_LINES; k++) begin
            vec_mem[k] = 16'h8000 | 16'(k);
        end
        $readmemh("tb/adc_rx_vectors.txt", vec_mem);

        n_lines = 0;
        while (n_lines < MAX_LINES && vec_mem[n_lines*FIELDS][15:8] == 8'h00) begin
            n_lines++;
        end
        if (n_lines == 0) stop_on_error("Vector file is empty or missing");

        // Hold the first line's words during reset so the lane history is filled
        sync_rst  = 1'b1;
        frame_raw = vec_mem[0][7:0];
        lane0_raw = vec_mem[1][7:0];
        lane1_raw = vec_mem[2][7:0];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Reset
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int c = 0; c < 8; c++) begin
            wait_edge(1'b1);
            if (c == 7) sync_rst <= 1'b0;
        end
        wait_edge(1'b0);
        compare_value("bitslip", 16'(bitslip), 16'h0, -1);
        compare_value("bitslip_count", 16'(bitslip_count), 16'h0, -1);
        compare_value("frame_valid", 16'(frame_valid), 16'h0, -1);
        compare_value("locked", 16'(locked), 16'h0, -1);
        compare_value("sample_valid", 16'(sample_valid), 16'h0, -1);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Vector replay
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int i = 0; i < n_lines; i++) begin
            wait_edge(1'b1);
            frame_raw <= vec_mem[i*FIELDS+0][7:0];
            lane0_raw <= vec_mem[i*FIELDS+1][7:0];
            lane1_raw <= vec_mem[i*FIELDS+2][7:0];
            wait_edge(1'b0);   // Outputs settle well before the falling edge
            check_line(i);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: tb/adc_rx_properties.sv
`timescale 1ns/100ps

module adc_rx_properties (
    input logic       data_clk_div_internal,
    input logic       sync_rst,
    input logic       bitslip,
    input logic [2:0] bitslip_count,
    input logic       frame_valid,
    input logic       locked,
    input logic       sample_valid
);

    // Three idle cycles follow every slip
    slip_spacing: assert property (@(posedge data_clk_div_internal) disable iff (sync_rst)
        bitslip |-> !$past(bitslip, 1) && !$past(bitslip, 2) && !$past(bitslip, 3))
        else $error("bitslip pulses closer than the slip wait");

    sample_needs_lock: assert property (@(posedge data_clk_div_internal)
        sample_valid |-> locked)
        else $error("sample_valid high while not locked");

    reset_state: assert property (@(posedge data_clk_div_internal)
        sync_rst |-> !bitslip && !frame_valid && !locked && !sample_valid
                     && bitslip_count == 3'd0)
        else $error("outputs not cleared during reset");

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic data_clk_div_internal
);

    // Starts low so the first rising edge lands at half a period
    initial begin
        data_clk_div_internal = 1'b0;
        forever #(PERIOD_NS / 2.0) data_clk_div_internal = ~data_clk_div_internal;
    end

endmodule

// File: design/adc_rx_top.sv
`timescale 1ns/100ps

module adc_rx_top (
    input  logic                     data_clk_div_internal,
    input  logic                     sync_rst,
    input  adc_rx_pkg::lane_word_t   frame_raw,
    input  adc_rx_pkg::lane_word_t   lane0_raw,
    input  adc_rx_pkg::lane_word_t   lane1_raw,
    output logic                     bitslip,
    output adc_rx_pkg::slip_offset_t bitslip_count,
    output logic                     frame_valid,
    output logic                     locked,
    output logic                     sample_valid,
    output adc_rx_pkg::sample_t      sample
);

    import adc_rx_pkg::*;

    // Aligned words from the slip stage
    lane_word_t frame_word;
    lane_word_t lane0_word;
    lane_word_t lane1_word;

    word_slip u_word_slip (
        .data_clk_div_internal (data_clk_div_internal),
        .sync_rst              (sync_rst),
        .bitslip               (bitslip),   // Fed back from the frame checker
        .frame_raw             (frame_raw),
        .lane0_raw             (lane0_raw),
        .lane1_raw             (lane1_raw),
        .frame_word            (frame_word),
        .lane0_word            (lane0_word),
        .lane1_word            (lane1_word)
    );

    frame_align u_frame_align (
        .data_clk_div_internal (data_clk_div_internal),
        .sync_rst              (sync_rst),
        .frame_word            (frame_word),
        .bitslip               (bitslip),
        .bitslip_count         (bitslip_count),
        .frame_valid           (frame_valid)
    );

    sample_assembler u_sample_assembler (
        .data_clk_div_internal (data_clk_div_internal),
        .sync_rst              (sync_rst),
        .frame_valid           (frame_valid),
        .lane0_word            (lane0_word),
        .lane1_word            (lane1_word),
        .locked                (locked),
        .sample_valid          (sample_valid),
        .sample                (sample)
    );

endmodule

// File: design/sample_assembler.sv
`timescale 1ns/100ps

`include "adc_rx_defines.svh"

module sample_assembler (
    input  logic                   data_clk_div_internal,
    input  logic                   sync_rst,
    input  logic                   frame_valid,
    input  adc_rx_pkg::lane_word_t lane0_word,
    input  adc_rx_pkg::lane_word_t lane1_word,
    output logic                   locked,
    output logic                   sample_valid,
    output adc_rx_pkg::sample_t    sample
);

    import adc_rx_pkg::*;

    localparam int RUN_W     = $clog2(`ADC_RX_LOCK_COUNT + 1);
    localparam int LOCK_LAST = `ADC_RX_LOCK_COUNT - 1;

    lock_state_e      state;
    logic [RUN_W-1:0] run_cnt;   // Good frames seen in a row while unlocked
    lane_word_t       lane0_d;
    lane_word_t       lane1_d;
    logic             take_sample;

    assign locked      = (state == LOCKED);
    assign take_sample = locked && frame_valid;

    // Lane words arrive one cycle ahead of the frame check, so hold them back
    always_ff @(posedge data_clk_div_internal) begin
        lane0_d <= lane0_word;
        lane1_d <= lane1_word;
        if (take_sample) begin
            sample <= {lane1_d, lane0_d};   // Lane 1 is the upper byte
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lock tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge data_clk_div_internal or posedge sync_rst) begin
        if (sync_rst) begin
            state        <= UNLOCKED;
            run_cnt      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= take_sample;
            if (!frame_valid) begin
                // A single bad frame drops the link and restarts the run
                state   <= UNLOCKED;
                run_cnt <= '0;
            end else if (state == UNLOCKED) begin
                if (run_cnt == RUN_W'(LOCK_LAST)) begin
                    state <= LOCKED;   // This is the last frame of the run
                end else begin
                    run_cnt <= run_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: frame_align/frame_align.sv
`timescale 1ns/100ps

`include "adc_rx_defines.svh"

module frame_align (
    input  logic                     data_clk_div_internal,
    input  logic                     sync_rst,
    input  adc_rx_pkg::lane_word_t   frame_word,
    output logic                     bitslip,
    output adc_rx_pkg::slip_offset_t bitslip_count,
    output logic                     frame_valid
);

    import adc_rx_pkg::*;

    // Wide enough to hold the wait length itself
    localparam int WAIT_W    = $clog2(`ADC_RX_SLIP_WAIT + 1);
    localparam int WAIT_LAST = `ADC_RX_SLIP_WAIT - 1;

    align_state_e      state;
    logic [WAIT_W-1:0] wait_cnt;   // Cycles left in SLIP_WAIT
    logic              frame_match;

    assign frame_match = (frame_word == `ADC_RX_FRAME_PATTERN);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Good-frame flag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Reported in every state, the slip machine does not mask it
    always_ff @(posedge data_clk_div_internal or posedge sync_rst) begin
        if (sync_rst) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= frame_match;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bitslip controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A slip only shows in frame_word two cycles later, so the wait keeps the
    // machine from reacting to words that were taken at the old offset
    always_ff @(posedge data_clk_div_internal or posedge sync_rst) begin
        if (sync_rst) begin
            state         <= CHECK;
            wait_cnt      <= '0;
            bitslip       <= 1'b0;
            bitslip_count <= '0;
        end else begin
            bitslip <= 1'b0;   // Pulse lasts a single cycle
            case (state)
                CHECK: begin
                    if (!frame_match) begin
                        bitslip       <= 1'b1;
                        bitslip_count <= bitslip_count + 3'd1;   // Wraps with the offset
                        wait_cnt      <= WAIT_W'(WAIT_LAST);
                        state         <= SLIP_WAIT;
                    end
                end
                SLIP_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= CHECK;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/word_slip.sv
`timescale 1ns/100ps

`include "adc_rx_defines.svh"

module word_slip (
    input  logic                   data_clk_div_internal,
    input  logic                   sync_rst,
    input  logic                   bitslip,
    input  adc_rx_pkg::lane_word_t frame_raw,
    input  adc_rx_pkg::lane_word_t lane0_raw,
    input  adc_rx_pkg::lane_word_t lane1_raw,
    output adc_rx_pkg::lane_word_t frame_word,
    output adc_rx_pkg::lane_word_t lane0_word,
    output adc_rx_pkg::lane_word_t lane1_word
);

    import adc_rx_pkg::*;

    slip_offset_t offset;   // Shared by the frame lane and both data lanes
    lane_word_t   frame_prev;
    lane_word_t   lane0_prev;
    lane_word_t   lane1_prev;

    // Picks eight bits starting at bit ofs out of current word over previous word
    function automatic lane_word_t window(
        input lane_word_t   cur,
        input lane_word_t   prev,
        input slip_offset_t ofs
    );
        logic [2*`ADC_RX_WORD_W-1:0] pair;
        pair = {cur, prev} >> ofs;
        return pair[`ADC_RX_WORD_W-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Offset register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Each slip moves the window up by one bit, wrapping after eight
    always_ff @(posedge data_clk_div_internal or posedge sync_rst) begin
        if (sync_rst) begin
            offset <= '0;
        end else if (bitslip) begin
            offset <= offset + 3'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane history and realignment
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge data_clk_div_internal) begin
        frame_prev <= frame_raw;
        lane0_prev <= lane0_raw;
        lane1_prev <= lane1_raw;

        frame_word <= window(frame_raw, frame_prev, offset);
        lane0_word <= window(lane0_raw, lane0_prev, offset);   // Same offset on every lane
        lane1_word <= window(lane1_raw, lane1_prev, offset);
    end

endmodule

// File: common/adc_rx_pkg.sv
`include "adc_rx_defines.svh"

package adc_rx_pkg;

    // One parallel word from a single LVDS lane
    typedef logic [`ADC_RX_WORD_W-1:0] lane_word_t;

    typedef logic [2:0] slip_offset_t;  // Bit offset and slip count, both wrap modulo 8

    // Lane 1 forms the upper byte and lane 0 the lower byte
    typedef logic [`ADC_RX_LANES*`ADC_RX_WORD_W-1:0] sample_t;

    typedef enum logic {
        CHECK,
        SLIP_WAIT
    } align_state_e;

    typedef enum logic {
        UNLOCKED,
        LOCKED
    } lock_state_e;

endpackage

// File: common/adc_rx_defines.svh
`ifndef ADC_RX_DEFINES_SVH
`define ADC_RX_DEFINES_SVH

// Bits in one deserialized lane word
`define ADC_RX_WORD_W 8

// Number of data lanes joined into one sample
`define ADC_RX_LANES 2

// Aligned frame-lane word, four ones over four zeros
`define ADC_RX_FRAME_PATTERN 8'b1111_0000

// Idle cycles after a bitslip before another may be issued
`define ADC_RX_SLIP_WAIT 3

// Consecutive good frames before the link counts as locked
`define ADC_RX_LOCK_COUNT 4

`endif
